// File: logic/rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// data path width
`define RV_XLEN 32

// architectural registers, x8 and up alias onto x0..x7
`define RV_NREGS 8

// memory depths in 32-bit words
`define RV_IMEM_WORDS 64
`define RV_DMEM_WORDS 16

`endif

// File: logic/rvPkg.sv
`include "rv_macros.svh"

package rvPkg;

    // only the low bits of the 5-bit RISC-V field are kept
    typedef logic [$clog2(`RV_NREGS)-1:0] regAddr_t;

    // major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_IMM    = 7'b0010011,
        OP_STORE  = 7'b0100011,
        OP_REG    = 7'b0110011,
        OP_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } aluOp_e;

    // execute operand source
    typedef enum logic [1:0] {
        FWD_RF  = 2'b00,
        FWD_WB  = 2'b01,
        FWD_MEM = 2'b10
    } fwdSel_e;

    // all zero is a bubble
    typedef struct packed {
        logic     regWrite;
        logic     memRead;
        logic     memWrite;
        logic     branch;
        logic     useImm;
        aluOp_e   aluOp;
        regAddr_t rd;
        regAddr_t rs1;
        regAddr_t rs2;
    } ctrl_t;

endpackage

// File: logic/hazardIf.sv
`timescale 1ns/1ns

interface hazardIf
    import rvPkg::*;
();

    // pipeline state seen by the hazard unit
    regAddr_t rs1D;
    regAddr_t rs2D;
    regAddr_t rs1E;
    regAddr_t rs2E;
    regAddr_t rdE;
    logic     memReadE;
    logic     branchTakenE;
    regAddr_t rdM;
    logic     regWriteM;
    regAddr_t rdW;
    logic     regWriteW;

    // controls back to the pipeline
    fwdSel_e  forwardA;
    fwdSel_e  forwardB;
    logic     stallF;
    logic     stallD;
    logic     flushD;
    logic     flushE;

    modport pipe (
        output rs1D, rs2D, rs1E, rs2E, rdE, memReadE, branchTakenE,
        output rdM, regWriteM, rdW, regWriteW,
        input  forwardA, forwardB, stallF, stallD, flushD, flushE
    );

    modport hazard (
        input  rs1D, rs2D, rs1E, rs2E, rdE, memReadE, branchTakenE,
        input  rdM, regWriteM, rdW, regWriteW,
        output forwardA, forwardB, stallF, stallD, flushD, flushE
    );

endinterface

// File: logic/decoder.sv
`timescale 1ns/1ns
`include "rv_macros.svh"

module decoder
    import rvPkg::*;
(
    input  logic [`RV_XLEN-1:0] instr,
    output ctrl_t               ctrl,
    output logic [`RV_XLEN-1:0] imm
);

    logic [2:0] funct3;
    logic [6:0] funct7;
    regAddr_t   rdField;
    regAddr_t   rs1Field;
    regAddr_t   rs2Field;

    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign rdField  = instr[7 +: $bits(regAddr_t)];
    assign rs1Field = instr[15 +: $bits(regAddr_t)];
    assign rs2Field = instr[20 +: $bits(regAddr_t)];

    always_comb begin
        ctrl = '0;
        case (opcode_e'(instr[6:0]))
            OP_REG: begin
                ctrl.regWrite = 1'b1;
                ctrl.rd       = rdField;
                ctrl.rs1      = rs1Field;
                ctrl.rs2      = rs2Field;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: ctrl.aluOp = ALU_ADD;
                    {7'b0100000, 3'b000}: ctrl.aluOp = ALU_SUB;
                    {7'b0000000, 3'b111}: ctrl.aluOp = ALU_AND;
                    {7'b0000000, 3'b110}: ctrl.aluOp = ALU_OR;
                    {7'b0000000, 3'b100}: ctrl.aluOp = ALU_XOR;
                    {7'b0000000, 3'b010}: ctrl.aluOp = ALU_SLT;
                    default:              ctrl = '0;
                endcase
            end
            OP_IMM: begin
                // ADDI only
                if (funct3 == 3'b000) begin
                    ctrl.regWrite = 1'b1;
                    ctrl.useImm   = 1'b1;
                    ctrl.rd       = rdField;
                    ctrl.rs1      = rs1Field;
                end
            end
            OP_LOAD: begin
                if (funct3 == 3'b010) begin
                    ctrl.regWrite = 1'b1;
                    ctrl.memRead  = 1'b1;
                    ctrl.useImm   = 1'b1;
                    ctrl.rd       = rdField;
                    ctrl.rs1      = rs1Field;
                end
            end
            OP_STORE: begin
                if (funct3 == 3'b010) begin
                    ctrl.memWrite = 1'b1;
                    ctrl.useImm   = 1'b1;
                    ctrl.rs1      = rs1Field;
                    ctrl.rs2      = rs2Field;
                end
            end
            OP_BRANCH: begin
                // BEQ only, compared in execute
                if (funct3 == 3'b000) begin
                    ctrl.branch = 1'b1;
                    ctrl.rs1    = rs1Field;
                    ctrl.rs2    = rs2Field;
                end
            end
            default: ctrl = '0;
        endcase
    end

    always_comb begin
        case (opcode_e'(instr[6:0]))
            OP_STORE:  imm = {{(`RV_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
            OP_BRANCH: imm = {{(`RV_XLEN-13){instr[31]}}, instr[31], instr[7],
                              instr[30:25], instr[11:8], 1'b0};
            default:   imm = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
        endcase
    end

endmodule

// File: logic/regFile.sv
`timescale 1ns/1ns
`include "rv_macros.svh"

module regFile
    import rvPkg::*;
(
    input  logic                clk,
    input  logic                arstN,
    input  regAddr_t            rs1,
    input  regAddr_t            rs2,
    input  logic                we,
    input  regAddr_t            rd,
    input  logic [`RV_XLEN-1:0] wd,
    output logic [`RV_XLEN-1:0] rd1,
    output logic [`RV_XLEN-1:0] rd2
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];
    logic                weLive;

    // x0 is never written, so it stays at its reset value of zero
    assign weLive = we && (rd != '0);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (weLive) begin
            regs[rd] <= wd;
        end
    end

    // write-through so decode sees the value retiring this cycle
    assign rd1 = (weLive && rd == rs1) ? wd : regs[rs1];
    assign rd2 = (weLive && rd == rs2) ? wd : regs[rs2];

endmodule

// File: logic/hazardUnit.sv
`timescale 1ns/1ns

module hazardUnit
    import rvPkg::*;
(
    hazardIf.hazard hz
);

    logic loadUse;

    // memory stage is younger, so it wins over writeback
    function automatic fwdSel_e pickForward(
        input regAddr_t rs,
        input regAddr_t rdM,
        input logic     regWriteM,
        input regAddr_t rdW,
        input logic     regWriteW
    );
        fwdSel_e sel;
        if (rs == '0) begin
            sel = FWD_RF;
        end else if (regWriteM && rdM == rs) begin
            sel = FWD_MEM;
        end else if (regWriteW && rdW == rs) begin
            sel = FWD_WB;
        end else begin
            sel = FWD_RF;
        end
        return sel;
    endfunction

    assign hz.forwardA = pickForward(hz.rs1E, hz.rdM, hz.regWriteM, hz.rdW, hz.regWriteW);
    assign hz.forwardB = pickForward(hz.rs2E, hz.rdM, hz.regWriteM, hz.rdW, hz.regWriteW);

    // load in execute feeding the instruction in decode
    assign loadUse = hz.memReadE && (hz.rdE != '0) &&
                     (hz.rdE == hz.rs1D || hz.rdE == hz.rs2D);

    // hold fetch and decode one cycle unless a taken branch redirects
    assign hz.stallF = loadUse && !hz.branchTakenE;
    assign hz.stallD = loadUse && !hz.branchTakenE;

    // taken branch drops the two younger instructions,
    // a load-use stall leaves a bubble in execute
    assign hz.flushD = hz.branchTakenE;
    assign hz.flushE = hz.branchTakenE || loadUse;

endmodule

// File: logic/pipeline.sv
`timescale 1ns/1ns
`include "rv_macros.svh"

module pipeline
    import rvPkg::*;
(
    input  logic                               clk,
    input  logic                               arstN,
    input  logic                               run,
    input  logic                               loadEn,
    input  logic [$clog2(`RV_IMEM_WORDS)-1:0]  loadAddr,
    input  logic [`RV_XLEN-1:0]                loadData,
    hazardIf.pipe                              hz,
    output logic                               retireValid,
    output logic [`RV_XLEN-1:0]                retirePc,
    output regAddr_t                           retireRd,
    output logic [`RV_XLEN-1:0]                retireData
);

    localparam int IMEM_AW = $clog2(`RV_IMEM_WORDS);
    localparam int DMEM_AW = $clog2(`RV_DMEM_WORDS);

    // fetch
    logic [`RV_XLEN-1:0] imem [`RV_IMEM_WORDS];
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] instrF;

    // decode
    logic                validD;
    logic [`RV_XLEN-1:0] pcD;
    logic [`RV_XLEN-1:0] instrD;
    ctrl_t               ctrlD;
    logic [`RV_XLEN-1:0] immD;
    logic [`RV_XLEN-1:0] rd1D;
    logic [`RV_XLEN-1:0] rd2D;

    // execute
    logic                validE;
    ctrl_t               ctrlE;
    logic [`RV_XLEN-1:0] pcE;
    logic [`RV_XLEN-1:0] immE;
    logic [`RV_XLEN-1:0] rd1E;
    logic [`RV_XLEN-1:0] rd2E;
    logic [`RV_XLEN-1:0] srcA;
    logic [`RV_XLEN-1:0] fwdB;
    logic [`RV_XLEN-1:0] srcB;
    logic [`RV_XLEN-1:0] aluOut;
    logic [`RV_XLEN-1:0] targetE;
    logic                branchTakenE;

    // memory
    logic                validM;
    ctrl_t               ctrlM;
    logic [`RV_XLEN-1:0] pcM;
    logic [`RV_XLEN-1:0] aluResultM;
    logic [`RV_XLEN-1:0] storeDataM;
    logic [`RV_XLEN-1:0] dmem [`RV_DMEM_WORDS];
    logic [DMEM_AW-1:0]  dmemIdx;
    logic [`RV_XLEN-1:0] loadDataM;

    // writeback
    logic                validW;
    ctrl_t               ctrlW;
    logic [`RV_XLEN-1:0] pcW;
    logic [`RV_XLEN-1:0] resultW;
    logic                wbWe;

    function automatic logic [`RV_XLEN-1:0] fwdValue(
        input fwdSel_e             sel,
        input logic [`RV_XLEN-1:0] rfVal,
        input logic [`RV_XLEN-1:0] memVal,
        input logic [`RV_XLEN-1:0] wbVal
    );
        logic [`RV_XLEN-1:0] val;
        case (sel)
            FWD_MEM: val = memVal;
            FWD_WB:  val = wbVal;
            default: val = rfVal;
        endcase
        return val;
    endfunction

    // program load port, may write in any cycle
    always_ff @(posedge clk) begin
        if (loadEn) begin
            imem[loadAddr] <= loadData;
        end
    end

    assign instrF = imem[pc[IMEM_AW+1:2]];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (!run) begin
            pc <= '0;
        end else if (branchTakenE) begin
            pc <= targetE;
        end else if (!hz.stallF) begin
            pc <= pc + `RV_XLEN'(4);
        end
    end

    // IF/ID, a cleared slot holds the all-zero word which decodes as a no-op
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validD <= 1'b0;
            pcD    <= '0;
            instrD <= '0;
        end else if (hz.flushD || !run) begin
            validD <= 1'b0;
            instrD <= '0;
        end else if (!hz.stallD) begin
            validD <= 1'b1;
            pcD    <= pc;
            instrD <= instrF;
        end
    end

    decoder uDecoder (
        .instr (instrD),
        .ctrl  (ctrlD),
        .imm   (immD)
    );

    regFile uRegFile (
        .clk   (clk),
        .arstN (arstN),
        .rs1   (ctrlD.rs1),
        .rs2   (ctrlD.rs2),
        .we    (ctrlW.regWrite),
        .rd    (ctrlW.rd),
        .wd    (resultW),
        .rd1   (rd1D),
        .rd2   (rd2D)
    );

    // ID/EX
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validE <= 1'b0;
            ctrlE  <= '0;
            pcE    <= '0;
            immE   <= '0;
            rd1E   <= '0;
            rd2E   <= '0;
        end else if (hz.flushE) begin
            validE <= 1'b0;
            ctrlE  <= '0;
        end else begin
            validE <= validD;
            ctrlE  <= ctrlD;
            pcE    <= pcD;
            immE   <= immD;
            rd1E   <= rd1D;
            rd2E   <= rd2D;
        end
    end

    assign srcA = fwdValue(hz.forwardA, rd1E, aluResultM, resultW);
    assign fwdB = fwdValue(hz.forwardB, rd2E, aluResultM, resultW);
    assign srcB = ctrlE.useImm ? immE : fwdB;

    always_comb begin
        case (ctrlE.aluOp)
            ALU_SUB: aluOut = srcA - srcB;
            ALU_AND: aluOut = srcA & srcB;
            ALU_OR:  aluOut = srcA | srcB;
            ALU_XOR: aluOut = srcA ^ srcB;
            ALU_SLT: aluOut = {{(`RV_XLEN-1){1'b0}}, $signed(srcA) < $signed(srcB)};
            default: aluOut = srcA + srcB;
        endcase
    end

    // BEQ resolves here; bubbles carry a cleared branch bit
    assign targetE      = pcE + immE;
    assign branchTakenE = ctrlE.branch && (srcA == fwdB);

    // EX/MEM
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validM     <= 1'b0;
            ctrlM      <= '0;
            pcM        <= '0;
            aluResultM <= '0;
            storeDataM <= '0;
        end else begin
            validM     <= validE;
            ctrlM      <= ctrlE;
            pcM        <= pcE;
            aluResultM <= aluOut;
            storeDataM <= fwdB;
        end
    end

    // word index, byte offset bits ignored
    assign dmemIdx = aluResultM[DMEM_AW+1:2];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `RV_DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (ctrlM.memWrite) begin
            dmem[dmemIdx] <= storeDataM;
        end
    end

    assign loadDataM = dmem[dmemIdx];

    // MEM/WB
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validW  <= 1'b0;
            ctrlW   <= '0;
            pcW     <= '0;
            resultW <= '0;
        end else begin
            validW  <= validM;
            ctrlW   <= ctrlM;
            pcW     <= pcM;
            resultW <= ctrlM.memRead ? loadDataM : aluResultM;
        end
    end

    assign wbWe = ctrlW.regWrite && (ctrlW.rd != '0);

    assign retireValid = validW;
    assign retirePc    = pcW;
    assign retireRd    = wbWe ? ctrlW.rd : '0;
    assign retireData  = wbWe ? resultW : '0;

    // hazard unit inputs
    assign hz.rs1D         = ctrlD.rs1;
    assign hz.rs2D         = ctrlD.rs2;
    assign hz.rs1E         = ctrlE.rs1;
    assign hz.rs2E         = ctrlE.rs2;
    assign hz.rdE          = ctrlE.rd;
    assign hz.memReadE     = ctrlE.memRead;
    assign hz.branchTakenE = branchTakenE;
    assign hz.rdM          = ctrlM.rd;
    assign hz.regWriteM    = ctrlM.regWrite;
    assign hz.rdW          = ctrlW.rd;
    assign hz.regWriteW    = ctrlW.regWrite;

endmodule

// File: logic/rvCore.sv
`timescale 1ns/1ns
`include "rv_macros.svh"

module rvCore
    import rvPkg::*;
(
    input  logic                               clk,
    input  logic                               arstN,
    input  logic                               run,
    input  logic                               loadEn,
    input  logic [$clog2(`RV_IMEM_WORDS)-1:0]  loadAddr,
    input  logic [`RV_XLEN-1:0]                loadData,
    output logic                               retireValid,
    output logic [`RV_XLEN-1:0]                retirePc,
    output regAddr_t                           retireRd,
    output logic [`RV_XLEN-1:0]                retireData
);

    // hazard inputs out, forward and stall controls back
    hazardIf hzBus ();

    pipeline uPipeline (
        .clk         (clk),
        .arstN       (arstN),
        .run         (run),
        .loadEn      (loadEn),
        .loadAddr    (loadAddr),
        .loadData    (loadData),
        .hz          (hzBus.pipe),
        .retireValid (retireValid),
        .retirePc    (retirePc),
        .retireRd    (retireRd),
        .retireData  (retireData)
    );

    // purely combinational, controls act in the same cycle
    hazardUnit uHazardUnit (
        .hz (hzBus.hazard)
    );

endmodule

// File: bench/rvCore_assertions.sv
`timescale 1ns/1ns

module rvCore_assertions
    import rvPkg::*;
(
    input logic     clk,
    input logic     arstN,
    input logic     run,
    input logic     retireValid,
    input regAddr_t rs1D,
    input regAddr_t rs2D,
    input regAddr_t rdE,
    input logic     memReadE,
    input logic     stallF,
    input logic     stallD,
    input logic     flushD,
    input logic     flushE
);

    logic arstSeen;
    logic idleSinceReset;
    int   failCount = 0;

    // reset level at the previous edge
    always_ff @(posedge clk) begin
        arstSeen <= arstN;
    end

    // set by reset, cleared once the core is started
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            idleSinceReset <= 1'b1;
        end else if (run) begin
            idleSinceReset <= 1'b0;
        end
    end

    quietAfterReset: assert property (@(posedge clk)
        (arstN && !arstSeen) |-> !(stallF || stallD || flushD || flushE))
    else begin
        failCount = failCount + 1;
        $error("stall or flush active in the first cycle after reset");
    end

    // consumer stays in decode while execute takes the bubble
    loadUseBubble: assert property (@(posedge clk) disable iff (!arstN)
        (memReadE && rdE != '0 && (rdE == rs1D || rdE == rs2D))
        |=> ($past(flushE) && !memReadE && rdE == '0 &&
             $stable(rs1D) && $stable(rs2D)))
    else begin
        failCount = failCount + 1;
        $error("load-use hazard without a held decode and a bubble in execute");
    end

    noRetireWhileIdle: assert property (@(posedge clk) disable iff (!arstN)
        idleSinceReset |-> !retireValid)
    else begin
        failCount = failCount + 1;
        $error("retire seen before the core was started");
    end

endmodule

bind rvCore rvCore_assertions uAssertions (
    .clk         (clk),
    .arstN       (arstN),
    .run         (run),
    .retireValid (retireValid),
    .rs1D        (hzBus.rs1D),
    .rs2D        (hzBus.rs2D),
    .rdE         (hzBus.rdE),
    .memReadE    (hzBus.memReadE),
    .stallF      (hzBus.stallF),
    .stallD      (hzBus.stallD),
    .flushD      (hzBus.flushD),
    .flushE      (hzBus.flushE)
);

// File: bench/rvCoreTb.sv
`timescale 1ns/1ns
`include "rv_macros.svh"

module rvCoreTb;

    localparam int          numPrograms = 20;
    localparam int          progLen     = 24;
    localparam logic [31:0] progEnd     = 32'(progLen * 4);
    // 20 programs of roughly 115 cycles each, with margin
    localparam int          cycleLimit  = 4000;
    // addi x0, x0, 0
    localparam logic [31:0] nopWord     = 32'h00000013;

    // instruction kinds shared by the generator and the model
    localparam int kindAdd  = 0;
    localparam int kindSub  = 1;
    localparam int kindAnd  = 2;
    localparam int kindOr   = 3;
    localparam int kindXor  = 4;
    localparam int kindSlt  = 5;
    localparam int kindAddi = 6;
    localparam int kindLw   = 7;
    localparam int kindSw   = 8;
    localparam int kindBeq  = 9;

    logic                              clk;
    logic                              arstN;
    logic                              run;
    logic                              loadEn;
    logic [$clog2(`RV_IMEM_WORDS)-1:0] loadAddr;
    logic [`RV_XLEN-1:0]               loadData;
    logic                              retireValid;
    logic [`RV_XLEN-1:0]               retirePc;
    logic [2:0]                        retireRd;
    logic [`RV_XLEN-1:0]               retireData;

    integer seed;
    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;

    // generated program, one entry per instruction
    int kindArr [progLen];
    int rdArr   [progLen];
    int rs1Arr  [progLen];
    int rs2Arr  [progLen];
    int immArr  [progLen];

    // expected retire sequence
    logic [31:0] expPc   [$];
    logic [31:0] expRd   [$];
    logic [31:0] expData [$];

    rvCore UUT (
        .clk         (clk),
        .arstN       (arstN),
        .run         (run),
        .loadEn      (loadEn),
        .loadAddr    (loadAddr),
        .loadData    (loadData),
        .retireValid (retireValid),
        .retirePc    (retirePc),
        .retireRd    (retireRd),
        .retireData  (retireData)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("timeout: run did not finish within %0d cycles", cycleLimit);
            $display("checks %0d, errors %0d", checks, errors);
            $display("Regression failed");
            $finish;
        end
    end

    function automatic int randBelow(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r[15:0]) % n;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic makeProgram();
        for (int i = 0; i < progLen; i++) begin
            kindArr[i] = randBelow(10);
            rdArr[i]   = randBelow(8);
            rs1Arr[i]  = randBelow(8);
            rs2Arr[i]  = randBelow(8);
            immArr[i]  = randBelow(4096) - 2048;
            if (kindArr[i] == kindLw || kindArr[i] == kindSw) begin
                // x0 base, word offsets 0..60
                rs1Arr[i] = 0;
                immArr[i] = randBelow(16) * 4;
            end else if (kindArr[i] == kindBeq) begin
                // equal operands half the time so branches get taken
                if (randBelow(2) == 0) begin
                    rs2Arr[i] = rs1Arr[i];
                end
                immArr[i] = (randBelow(3) + 2) * 4;
            end
        end
    endtask

    // RV32I encodings
    function automatic logic [31:0] encode(input int i);
        logic [11:0] immI;
        logic [12:0] immB;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] word;
        immI = 12'(immArr[i]);
        immB = 13'(immArr[i]);
        rd   = 5'(rdArr[i]);
        rs1  = 5'(rs1Arr[i]);
        rs2  = 5'(rs2Arr[i]);
        case (kindArr[i])
            kindAdd:  word = {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
            kindSub:  word = {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
            kindAnd:  word = {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
            kindOr:   word = {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
            kindXor:  word = {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
            kindSlt:  word = {7'b0000000, rs2, rs1, 3'b010, rd, 7'b0110011};
            kindAddi: word = {immI, rs1, 3'b000, rd, 7'b0010011};
            kindLw:   word = {immI, rs1, 3'b010, rd, 7'b0000011};
            kindSw:   word = {immI[11:5], rs2, rs1, 3'b010, immI[4:0], 7'b0100011};
            default:  word = {immB[12], immB[10:5], rs2, rs1, 3'b000, immB[4:1], immB[11],
                              7'b1100011};
        endcase
        return word;
    endfunction

    // instruction-set model, one instruction at a time from address 0
    task automatic buildExpected();
        logic [31:0] regs [8];
        logic [31:0] mem [16];
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        logic [31:0] val;
        logic        writes;
        int          pc;
        int          i;
        int          nextPc;
        for (int r = 0; r < 8; r++) begin
            regs[r] = '0;
        end
        for (int w = 0; w < 16; w++) begin
            mem[w] = '0;
        end
        expPc.delete();
        expRd.delete();
        expData.delete();
        pc = 0;
        while (pc < progLen * 4) begin
            i      = pc / 4;
            a      = regs[rs1Arr[i]];
            b      = regs[rs2Arr[i]];
            addr   = a + 32'(immArr[i]);
            nextPc = pc + 4;
            writes = 1'b1;
            val    = '0;
            case (kindArr[i])
                kindAdd:  val = a + b;
                kindSub:  val = a - b;
                kindAnd:  val = a & b;
                kindOr:   val = a | b;
                kindXor:  val = a ^ b;
                kindSlt:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                kindAddi: val = addr;
                kindLw:   val = mem[addr[5:2]];
                kindSw: begin
                    mem[addr[5:2]] = b;
                    writes = 1'b0;
                end
                default: begin
                    if (a == b) begin
                        nextPc = pc + immArr[i];
                    end
                    writes = 1'b0;
                end
            endcase
            expPc.push_back(32'(pc));
            // x0 writes retire with rd and data at zero
            if (writes && rdArr[i] != 0) begin
                regs[rdArr[i]] = val;
                expRd.push_back(32'(rdArr[i]));
                expData.push_back(val);
            end else begin
                expRd.push_back('0);
                expData.push_back('0);
            end
            pc = nextPc;
        end
    endtask

    task automatic resetCore();
        @(posedge clk);
        arstN  <= 1'b0;
        run    <= 1'b0;
        loadEn <= 1'b0;
        repeat (10) @(posedge clk);
        arstN <= 1'b1;
    endtask

    task automatic loadProgram();
        for (int i = 0; i < `RV_IMEM_WORDS; i++) begin
            @(posedge clk);
            loadEn   <= 1'b1;
            loadAddr <= i[$bits(loadAddr)-1:0];
            loadData <= (i < progLen) ? encode(i) : nopWord;
        end
        @(posedge clk);
        loadEn <= 1'b0;
    endtask

    // start the core and match each retire against the model
    task automatic runAndCheck();
        logic done;
        done = 1'b0;
        @(posedge clk);
        run <= 1'b1;
        while (!done) begin
            @(negedge clk);
            if (retireValid) begin
                if (retirePc >= progEnd) begin
                    if (expPc.size() != 0) begin
                        errors = errors + 1;
                        $display("program ended with %0d instructions not retired",
                                 expPc.size());
                    end
                    done = 1'b1;
                end else if (expPc.size() == 0) begin
                    errors = errors + 1;
                    $display("unexpected retire at pc 0x%h after the program end", retirePc);
                end else begin
                    checkValue("retirePc", retirePc, expPc.pop_front());
                    checkValue("retireRd", 32'(retireRd), expRd.pop_front());
                    checkValue("retireData", retireData, expData.pop_front());
                end
            end
        end
        repeat (3) @(posedge clk);
        run <= 1'b0;
    endtask

    initial begin
        arstN    = 1'b0;
        run      = 1'b0;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        seed     = 32'hadb7;
        for (int p = 0; p < numPrograms; p++) begin
            resetCore();
            makeProgram();
            buildExpected();
            loadProgram();
            runAndCheck();
        end
        if (UUT.uAssertions.failCount != 0) begin
            $display("%0d assertion failures", UUT.uAssertions.failCount);
            errors = errors + UUT.uAssertions.failCount;
        end
        $display("programs %0d, checks %0d, errors %0d", numPrograms, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: rvCore.f
+incdir+logic
logic/rvPkg.sv
logic/hazardIf.sv
logic/decoder.sv
logic/regFile.sv
logic/hazardUnit.sv
logic/pipeline.sv
logic/rvCore.sv
bench/rvCore_assertions.sv
bench/rvCoreTb.sv

// File: run.sh
#!/bin/sh
# build the rvCore testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module rvCoreTb -f rvCore.f -o rvCoreSim \
    && { ./obj_dir/rvCoreSim +verilator+error+limit+100 > sim.log 2>&1 || true; } \
    && cat sim.log \
    && grep -qx "Regression passed" sim.log \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }
